// ==== Bender.yml ====
package:
  name: ram_subsys

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - mem_geom_pkg.sv
      - mem_port_pkg.sv
      - sram_bank_model.sv
      - bank_rdata_tree.sv
      - sp_ram_bank.sv
      - mem_range_guard.sv
      - ram_subsys.sv
  - target: test
    include_dirs:
      - .
    files:
      - ram_subsys_tb.sv

// ==== bank_rdata_tree.sv ====
`timescale 1ns/10ps

module bank_rdata_tree
  import mem_geom_pkg::*;
(
  input  bank_idx_t sel_i,
  input  word_t     bank_rdata_i [NUM_BANKS],
  output word_t     rdata_o
);

  // heap layout: node 0 is the root, children of n are 2n+1 and 2n+2
  // bank b sits at leaf NUM_BANKS-1+b
  localparam int unsigned NUM_NODES = 2 * NUM_BANKS - 1;

  word_t node [NUM_NODES];

  // leaves take the bank outputs
  for (genvar b = 0; b < NUM_BANKS; b++)
  begin : g_leaf
    assign node[NUM_BANKS-1+b] = bank_rdata_i[b];
  end

  // one level per index bit
  // the msb steers the root, the lsb steers the level above the leaves
  for (genvar lvl = 0; lvl < BANK_IDX_W; lvl++)
  begin : g_level
    for (genvar k = 0; k < 2**lvl; k++)
    begin : g_node
      localparam int unsigned NODE_IDX = 2**lvl - 1 + k;
      localparam int unsigned SEL_BIT  = BANK_IDX_W - 1 - lvl;

      // odd child is the lower half of the index range
      assign node[NODE_IDX] = sel_i[SEL_BIT] ? node[2*NODE_IDX+2]
                                             : node[2*NODE_IDX+1];
    end
  end

  assign rdata_o = node[0];

endmodule

// ==== mem_config.svh ====
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

// width of the port word address
// 4096 words addressable by default
`define MEM_ADDR_WIDTH 12

// data word width, a multiple of 8
`define MEM_DATA_WIDTH 32

// number of banks, power of two and at least 2
`define MEM_NUM_BANKS 4

// words per bank, power of two
`define MEM_BANK_WORDS 512

// implemented words
// addresses at or above this are out of range
`define MEM_RANGE_WORDS (`MEM_NUM_BANKS * `MEM_BANK_WORDS)

`endif

// ==== mem_geom_pkg.sv ====
package mem_geom_pkg;

  `include "mem_config.svh"

  // geometry constants derived from the config macros
  localparam int unsigned ADDR_W      = `MEM_ADDR_WIDTH;
  localparam int unsigned DATA_W      = `MEM_DATA_WIDTH;
  localparam int unsigned NUM_BANKS   = `MEM_NUM_BANKS;
  localparam int unsigned BANK_WORDS  = `MEM_BANK_WORDS;
  localparam int unsigned RANGE_WORDS = `MEM_RANGE_WORDS;

  localparam int unsigned BANK_IDX_W  = $clog2(NUM_BANKS);
  localparam int unsigned BANK_ADDR_W = $clog2(BANK_WORDS);

  // one data word
  typedef logic [DATA_W-1:0] word_t;

  // word address at the port
  typedef logic [ADDR_W-1:0] addr_t;

  // bank select, taken from the bits above the in-bank address
  typedef logic [BANK_IDX_W-1:0] bank_idx_t;

  // word address inside one bank
  typedef logic [BANK_ADDR_W-1:0] bank_addr_t;

endpackage

// ==== mem_port_pkg.sv ====
package mem_port_pkg;

  `include "mem_config.svh"

  import mem_geom_pkg::*;

  localparam int unsigned LANE_W    = 8;
  localparam int unsigned NUM_LANES = `MEM_DATA_WIDTH / LANE_W;

  // byte enables, active high at the port
  typedef logic [NUM_LANES-1:0] be_t;

  // one byte lane of a word
  typedef logic [LANE_W-1:0] lane_t;

  // pick byte lane idx out of a word
  function automatic lane_t lane_of(input word_t w, input int unsigned idx);
    return w[idx*LANE_W +: LANE_W];
  endfunction

  // old word with the enabled lanes taken from the new word
  function automatic word_t merge_bytes(input word_t old_word, input word_t new_word,
                                        input be_t be);
    word_t result;
    result = old_word;
    for (int unsigned i = 0; i < NUM_LANES; i++)
    begin
      if (be[i])
        result[i*LANE_W +: LANE_W] = lane_of(new_word, i);
    end
    return result;
  endfunction

endpackage

// ==== mem_range_guard.sv ====
`timescale 1ns/10ps

module mem_range_guard
  import mem_geom_pkg::*;
(
  input  logic  clk_i,
  input  logic  rstn_i,
  input  logic  en_i,
  input  logic  we_i,
  input  addr_t addr_i,
  input  word_t mem_rdata_i,
  output logic  en_o,
  output word_t rdata_o,
  output logic  err_o
);

  logic in_range;
  logic err_q;
  logic zero_q;

  // implemented words start at zero, so one compare is enough
  assign in_range = (addr_i < RANGE_WORDS);

  // out-of-range accesses never reach a bank
  assign en_o = en_i && in_range;

  always_ff @(posedge clk_i or negedge rstn_i)
  begin
    if (!rstn_i)
    begin
      err_q  <= 1'b0;
      zero_q <= 1'b0;
    end
    else
    begin
      // one-cycle pulse per blocked access
      err_q <= en_i && !in_range;
      // follows the read whose data is on rdata_o
      if (en_i && !we_i)
        zero_q <= !in_range;
    end
  end

  assign err_o   = err_q;
  assign rdata_o = zero_q ? '0 : mem_rdata_i;

endmodule

// ==== ram_subsys.sv ====
`timescale 1ns/10ps

module ram_subsys
  import mem_geom_pkg::*;
  import mem_port_pkg::*;
(
  input  logic  clk_i,
  input  logic  rstn_i,
  input  logic  en_i,
  input  logic  we_i,
  input  be_t   be_i,
  input  addr_t addr_i,
  input  word_t wdata_i,
  output word_t rdata_o,
  output logic  err_o
);

  // gated strobe and raw read data between guard and memory
  logic  mem_en;
  word_t mem_rdata;

  mem_range_guard u_guard
  (
    .clk_i       ( clk_i     ),
    .rstn_i      ( rstn_i    ),
    .en_i        ( en_i      ),
    .we_i        ( we_i      ),
    .addr_i      ( addr_i    ),
    .mem_rdata_i ( mem_rdata ),
    .en_o        ( mem_en    ),
    .rdata_o     ( rdata_o   ),
    .err_o       ( err_o     )
  );

  sp_ram_bank u_mem
  (
    .clk_i   ( clk_i     ),
    .rstn_i  ( rstn_i    ),
    .en_i    ( mem_en    ),
    .we_i    ( we_i      ),
    .be_i    ( be_i      ),
    .addr_i  ( addr_i    ),
    .wdata_i ( wdata_i   ),
    .rdata_o ( mem_rdata )
  );

endmodule

// ==== ram_subsys_tb.sv ====
`timescale 1ns/10ps

`include "mem_config.svh"

module ram_subsys_tb
  import mem_geom_pkg::*;
  import mem_port_pkg::*;
();

  localparam int RESET_CYCLES  = 4;
  localparam int RESET_TIMEOUT = 20;
  localparam int NUM_RANDOM    = 64;

  logic  clk_i;
  logic  rstn_i;
  logic  en_i;
  logic  we_i;
  be_t   be_i;
  addr_t addr_i;
  word_t wdata_i;
  word_t rdata_o;
  logic  err_o;

  // reference contents of the implemented words
  word_t model [`MEM_RANGE_WORDS];

  logic [31:0] lcg_state = 32'hc45b;

  ram_subsys u_ram_subsys
  (
    .clk_i   ( clk_i   ),
    .rstn_i  ( rstn_i  ),
    .en_i    ( en_i    ),
    .we_i    ( we_i    ),
    .be_i    ( be_i    ),
    .addr_i  ( addr_i  ),
    .wdata_i ( wdata_i ),
    .rdata_o ( rdata_o ),
    .err_o   ( err_o   )
  );

  initial clk_i = 1'b0;
  always #4 clk_i = ~clk_i;

  initial
  begin
    rstn_i = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    #1 rstn_i = 1'b1;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // byte lanes with be high come from the new word
  function automatic word_t apply_byte_mask(input word_t old_w, input word_t new_w,
                                            input be_t be);
    word_t mask;
    mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    return (old_w & ~mask) | (new_w & mask);
  endfunction

  function automatic addr_t random_addr();
    return addr_t'((lcg_next() >> 8) % `MEM_RANGE_WORDS);
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected)
    begin
      $display("mismatch %s expected %08h actual %08h", name, expected, actual);
      $display("Test failed");
      $fatal(1, "value check failed in %s", name);
    end
  endtask

  // outputs are sampled here, inputs change right after
  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  task automatic set_idle();
    en_i    = 1'b0;
    we_i    = 1'b0;
    be_i    = '0;
    addr_i  = '0;
    wdata_i = '0;
  endtask

  task automatic drive_access(input logic we, input addr_t addr, input word_t data,
                              input be_t be);
    en_i    = 1'b1;
    we_i    = we;
    be_i    = be;
    addr_i  = addr;
    wdata_i = data;
  endtask

  task automatic wait_reset_release();
    int cycles;
    cycles = 0;
    while (rstn_i !== 1'b1)
    begin
      if (cycles >= RESET_TIMEOUT)
      begin
        $display("Test failed");
        $fatal(1, "timed out waiting for reset release");
      end
      next_cycle();
      cycles++;
    end
  endtask

  // drives one write and leaves the port idle afterwards
  task automatic do_write(input addr_t addr, input word_t data, input be_t be);
    drive_access(1'b1, addr, data, be);
    next_cycle();
    set_idle();
    if (addr < `MEM_RANGE_WORDS)
      model[addr] = apply_byte_mask(model[addr], data, be);
  endtask

  task automatic do_read(input string name, input addr_t addr);
    drive_access(1'b0, addr, '0, '0);
    next_cycle();
    set_idle();
    check_value(name, 32'd0, {31'd0, err_o});
    next_cycle();
    check_value(name, model[addr], rdata_o);
  endtask

  task automatic test_reset();
    check_value("test_reset", 32'd0, {31'd0, err_o});
    for (int i = 0; i < 5; i++)
    begin
      next_cycle();
      check_value("test_reset", 32'd0, {31'd0, err_o});
    end
  endtask

  task automatic test_bank_walk();
    int offs [3];
    addr_t addr;
    offs[0] = 0;
    offs[1] = `MEM_BANK_WORDS / 2;
    offs[2] = `MEM_BANK_WORDS - 1;
    for (int b = 0; b < `MEM_NUM_BANKS; b++)
      for (int k = 0; k < 3; k++)
      begin
        addr = addr_t'(b * `MEM_BANK_WORDS + offs[k]);
        do_write(addr, {8'(b), 8'(k), 16'(lcg_next())}, 4'hf);
      end
    for (int b = 0; b < `MEM_NUM_BANKS; b++)
      for (int k = 0; k < 3; k++)
        do_read("test_bank_walk", addr_t'(b * `MEM_BANK_WORDS + offs[k]));
  endtask

  task automatic test_byte_enables();
    be_t   masks [10];
    addr_t addr;
    masks = '{4'h1, 4'h2, 4'h4, 4'h8, 4'h5, 4'ha, 4'h3, 4'hc, 4'h0, 4'he};
    for (int n = 0; n < `MEM_NUM_BANKS; n++)
    begin
      addr = addr_t'(n * `MEM_BANK_WORDS + 17 + n);
      do_write(addr, lcg_next(), 4'hf);
      do_read("test_byte_enables", addr);
      foreach (masks[m])
      begin
        do_write(addr, lcg_next(), masks[m]);
        do_read("test_byte_enables", addr);
      end
    end
  endtask

  task automatic test_back_to_back();
    addr_t addrs [NUM_RANDOM];
    word_t expected [NUM_RANDOM];
    word_t last;
    for (int i = 0; i < NUM_RANDOM; i++)
    begin
      addrs[i] = random_addr();
      drive_access(1'b1, addrs[i], lcg_next(), 4'hf);
      model[addrs[i]] = wdata_i;
      next_cycle();
    end
    set_idle();
    // one read per cycle, each word shows up right after its read is taken
    for (int i = 0; i < NUM_RANDOM; i++)
    begin
      expected[i] = model[addrs[i]];
      drive_access(1'b0, addrs[i], '0, '0);
      next_cycle();
      check_value("test_back_to_back", expected[i], rdata_o);
    end
    set_idle();
    next_cycle();
    last = expected[NUM_RANDOM-1];
    check_value("test_back_to_back", last, rdata_o);
    // a write, even to the same word, leaves rdata_o alone
    do_write(addrs[NUM_RANDOM-1], ~last, 4'hf);
    check_value("test_back_to_back", last, rdata_o);
    next_cycle();
    check_value("test_back_to_back", last, rdata_o);
    do_read("test_back_to_back", addrs[NUM_RANDOM-1]);
  endtask

  task automatic test_out_of_range();
    addr_t oor [3];
    addr_t alias_addr;
    oor[0] = addr_t'(`MEM_RANGE_WORDS);
    oor[1] = addr_t'(`MEM_RANGE_WORDS + 700);
    oor[2] = '1;
    // known words where the blocked accesses would land if decoded
    for (int i = 0; i < 3; i++)
      do_write(addr_t'(oor[i] % `MEM_RANGE_WORDS), lcg_next() | 32'h1, 4'hf);
    for (int i = 0; i < 3; i++)
    begin
      alias_addr = addr_t'(oor[i] % `MEM_RANGE_WORDS);
      do_read("test_out_of_range", alias_addr);
      drive_access(1'b1, oor[i], lcg_next(), 4'hf);
      next_cycle();
      set_idle();
      check_value("test_out_of_range", 32'd1, {31'd0, err_o});
      next_cycle();
      check_value("test_out_of_range", 32'd0, {31'd0, err_o});
      check_value("test_out_of_range", model[alias_addr], rdata_o);
      drive_access(1'b0, oor[i], '0, '0);
      next_cycle();
      set_idle();
      check_value("test_out_of_range", 32'd1, {31'd0, err_o});
      next_cycle();
      check_value("test_out_of_range", 32'd0, {31'd0, err_o});
      check_value("test_out_of_range", 32'd0, rdata_o);
      next_cycle();
      check_value("test_out_of_range", 32'd0, rdata_o);
    end
    for (int i = 0; i < 3; i++)
      do_read("test_out_of_range", addr_t'(oor[i] % `MEM_RANGE_WORDS));
  endtask

  initial
  begin
    set_idle();
    wait_reset_release();
    test_reset();
    test_bank_walk();
    test_byte_enables();
    test_back_to_back();
    test_out_of_range();
    $display("Test completed successfully");
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+.
mem_geom_pkg.sv
mem_port_pkg.sv
sram_bank_model.sv
bank_rdata_tree.sv
sp_ram_bank.sv
mem_range_guard.sv
ram_subsys.sv
ram_subsys_tb.sv

// ==== sp_ram_bank.sv ====
`timescale 1ns/10ps

module sp_ram_bank
  import mem_geom_pkg::*;
  import mem_port_pkg::*;
(
  input  logic  clk_i,
  input  logic  rstn_i,
  input  logic  en_i,
  input  logic  we_i,
  input  be_t   be_i,
  input  addr_t addr_i,
  input  word_t wdata_i,
  output word_t rdata_o
);

  // address split
  bank_idx_t  bank_idx;
  bank_addr_t bank_addr;

  // pins shared by all banks
  logic wen;
  be_t  ben;

  // per-bank chip select and read data
  logic  csn [NUM_BANKS];
  word_t bank_q [NUM_BANKS];

  // bank of the last accepted read
  bank_idx_t bank_idx_q;

  // upper bits pick the bank, lower bits the word inside it
  // bits above the implemented range are left to the enable gating
  assign bank_idx  = addr_i[BANK_ADDR_W +: BANK_IDX_W];
  assign bank_addr = addr_i[BANK_ADDR_W-1:0];

  assign wen = ~we_i;
  assign ben = ~be_i;

  for (genvar b = 0; b < NUM_BANKS; b++)
  begin : g_bank
    // active low select, only the addressed bank sees the access
    assign csn[b] = ~(en_i && (bank_idx == bank_idx_t'(b)));

    sram_bank_model u_bank
    (
      .clk_i ( clk_i     ),
      .csn_i ( csn[b]    ),
      .wen_i ( wen       ),
      .ben_i ( ben       ),
      .a_i   ( bank_addr ),
      .d_i   ( wdata_i   ),
      .q_o   ( bank_q[b] )
    );
  end

  // track which bank will present data next cycle
  // writes leave it alone so rdata_o holds
  always_ff @(posedge clk_i or negedge rstn_i)
  begin
    if (!rstn_i)
    begin
      bank_idx_q <= '0;
    end
    else if (en_i && !we_i)
    begin
      bank_idx_q <= bank_idx;
    end
  end

  bank_rdata_tree u_tree
  (
    .sel_i        ( bank_idx_q ),
    .bank_rdata_i ( bank_q     ),
    .rdata_o      ( rdata_o    )
  );

endmodule

// ==== sram_bank_model.sv ====
`timescale 1ns/10ps

module sram_bank_model
  import mem_geom_pkg::*;
  import mem_port_pkg::*;
(
  input  logic       clk_i,
  input  logic       csn_i,
  input  logic       wen_i,
  input  be_t        ben_i,
  input  bank_addr_t a_i,
  input  word_t      d_i,
  output word_t      q_o
);

  // storage array, contents undefined until written
  word_t mem [BANK_WORDS];

  // pins are active low, so flip the lane mask once here
  be_t lane_en;

  assign lane_en = ~ben_i;

  // write port
  always_ff @(posedge clk_i)
  begin
    if (!csn_i && !wen_i)
    begin
      mem[a_i] <= merge_bytes(mem[a_i], d_i, lane_en);
    end
  end

  // read port, one cycle latency
  // q holds while the bank is idle or being written
  always_ff @(posedge clk_i)
  begin
    if (!csn_i && wen_i)
    begin
      q_o <= mem[a_i];
    end
  end

endmodule
